// File: Makefile
VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= fetch_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= sim passed

BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/fetch_patterns.txt
# m <word index hex> <64-bit beat hex>   memory image, upper half at pc bit 2 set
# s <npc hex> <stall cycles>              one decode handoff per line, in order
# f <count>                               expected final fetch_count
m 00 0020011300100093
m 01 0040021300300193
m 02 0060031300500293
m 03 0080041300700393
m 04 00a0051300900493
m 05 00c0061300b00593
m 06 00e0071300d00693
m 07 0010007300f00793
s 80000004 0
s 80000010 2
s 8000000c 0
s 80000028 1
s 80000014 3
s 80000030 0
s 80000024 2
s 8000003c 0
s 80000040 1
f 9

// File: bench/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb import fetch_pkg::*;;

  localparam addr_t RESET_PC     = 32'h8000_0000;
  localparam int    MEM_WORDS    = 64;
  localparam int    MEM_LATENCY  = 2;
  localparam int    IDX_W        = $clog2(MEM_WORDS);
  localparam int    HALT_CYCLES  = 20;
  localparam string PATTERN_FILE = "bench/fetch_patterns.txt";

  // test slots
  localparam int T_RESET    = 0;
  localparam int T_REDIRECT = 1;
  localparam int T_BACKPRES = 2;
  localparam int T_HALT     = 3;
  localparam int T_COUNTERS = 4;
  localparam int N_TESTS    = 5;

  logic             clk;
  logic             rstn;
  addr_t            npc;
  addr_t            pc;
  inst_t            inst;
  logic             inst_valid;
  logic             inst_ready;
  logic             halted;
  logic             load_en;
  logic [IDX_W-1:0] load_addr;
  beat_t            load_data;
  cnt_t             fetch_count;
  cnt_t             wait_mem_cycles;
  cnt_t             wait_exu_cycles;

  // reference copy of the memory
  beat_t image [MEM_WORDS];
  bit    image_loaded [MEM_WORDS];

  int    load_idx_q[$];
  beat_t load_beat_q[$];
  addr_t step_npc_q[$];
  int    step_stall_q[$];
  int    expect_fetches;
  bit    patterns_ready;

  string test_name [N_TESTS] = '{"reset_fetch", "redirect", "back_pressure", "halt", "counters"};
  int    test_errors [N_TESTS];
  int    total_stalls;
  int    accepted;

  fetch_top #(
    .RESET_PC   (RESET_PC),
    .MEM_WORDS  (MEM_WORDS),
    .MEM_LATENCY(MEM_LATENCY)
  ) fetch_top_inst (
    .clk            (clk),
    .rstn           (rstn),
    .npc            (npc),
    .pc             (pc),
    .inst           (inst),
    .inst_valid     (inst_valid),
    .inst_ready     (inst_ready),
    .halted         (halted),
    .load_en        (load_en),
    .load_addr      (load_addr),
    .load_data      (load_data),
    .fetch_count    (fetch_count),
    .wait_mem_cycles(wait_mem_cycles),
    .wait_exu_cycles(wait_exu_cycles)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic flag_mismatch(input int t, input string sig, input logic [31:0] got,
                               input logic [31:0] exp);
    $display("[FAIL] %s %s: got %h, expected %h", test_name[t], sig, got, exp);
    test_errors[t]++;
  endtask

  task automatic report_problem(input int t, input string msg);
    $display("error in %s: %s", test_name[t], msg);
    test_errors[t]++;
  endtask

  task automatic print_test_result(input int t);
    if (test_errors[t] == 0) begin
      $display("test %s: ok", test_name[t]);
    end else begin
      $display("test %s: %0d errors", test_name[t], test_errors[t]);
    end
  endtask

  // half of the image word selected by pc bit 2
  function automatic inst_t expected_inst(input addr_t a);
    addr_t word;
    beat_t beat;
    word = a >> 3;
    beat = image[int'(word % addr_t'(MEM_WORDS))];
    return a[2] ? beat[63:32] : beat[31:0];
  endfunction

  // image word holding this address came from the pattern file
  function automatic bit word_loaded(input addr_t a);
    addr_t word;
    word = a >> 3;
    return image_loaded[int'(word % addr_t'(MEM_WORDS))];
  endfunction

  // m <word index> <beat>, s <npc> <stall>, f <fetch count>
  task automatic read_patterns();
    int    fd;
    int    n;
    int    idx;
    int    val;
    string line;
    byte   key;
    addr_t a;
    beat_t b;
    fd = $fopen(PATTERN_FILE, "r");
    if (fd == 0) begin
      report_problem(T_RESET, $sformatf("cannot open %s", PATTERN_FILE));
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 0) begin
          key = line[0];
          if (key == "m") begin
            n = $sscanf(line, "m %h %h", idx, b);
            load_idx_q.push_back(idx);
            load_beat_q.push_back(b);
            image[idx % MEM_WORDS] = b;
            image_loaded[idx % MEM_WORDS] = 1'b1;
          end else if (key == "s") begin
            n = $sscanf(line, "s %h %d", a, val);
            step_npc_q.push_back(a);
            step_stall_q.push_back(val);
          end else if (key == "f") begin
            n = $sscanf(line, "f %d", val);
            expect_fetches = val;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic preload_memory();
    int k;
    for (k = 0; k < load_idx_q.size(); k++) begin
      @(posedge clk);
      #1;
      load_en   = 1'b1;
      load_addr = IDX_W'(load_idx_q[k]);
      load_data = load_beat_q[k];
    end
    @(posedge clk);
    #1;
    load_en = 1'b0;
  endtask

  task automatic wait_for_valid();
    while (inst_valid !== 1'b1) begin
      @(posedge clk);
      #1;
    end
  endtask

  // one decode handoff: check, stall, accept
  task automatic run_step(input int i);
    int    t;
    int    stall;
    addr_t exp_pc;
    inst_t exp_inst;
    addr_t held_pc;
    inst_t held_inst;
    t      = (i == 0) ? T_RESET : T_REDIRECT;
    exp_pc = (i == 0) ? RESET_PC : step_npc_q[i-1];
    npc    = step_npc_q[i];
    wait_for_valid();
    exp_inst = expected_inst(exp_pc);
    if (!word_loaded(exp_pc)) begin
      report_problem(t, $sformatf("step %0d fetches a word missing from the image", i));
    end
    if (pc !== exp_pc) begin
      flag_mismatch(t, "pc", pc, exp_pc);
    end
    if (inst !== exp_inst) begin
      flag_mismatch(t, "inst", inst, exp_inst);
    end
    if (halted !== 1'b0) begin
      flag_mismatch(T_HALT, "halted", 32'(halted), 32'h0);
    end
    stall = step_stall_q[i] + int'($urandom % 4);
    total_stalls += stall;
    held_pc   = pc;
    held_inst = inst;
    repeat (stall) begin
      @(posedge clk);
      #1;
      if (inst_valid !== 1'b1) begin
        flag_mismatch(T_BACKPRES, "inst_valid", 32'(inst_valid), 32'h1);
      end
      if (pc !== held_pc) begin
        flag_mismatch(T_BACKPRES, "pc", pc, held_pc);
      end
      if (inst !== held_inst) begin
        flag_mismatch(T_BACKPRES, "inst", inst, held_inst);
      end
    end
    inst_ready = 1'b1;
    @(posedge clk);
    #1;
    inst_ready = 1'b0;
    accepted++;
  endtask

  // watchdog sized from the number of steps
  initial begin
    wait (patterns_ready);
    repeat (step_npc_q.size() * (MEM_LATENCY + 12) + 200) @(posedge clk);
    $display("timeout: the fetch unit stopped responding");
    $display("sim failed");
    $finish;
  end

  initial begin
    int    i;
    int    failed_tests;
    int    error_total;
    addr_t last_pc;
    rstn       = 1'b0;
    npc        = RESET_PC;
    inst_ready = 1'b0;
    load_en    = 1'b0;
    load_addr  = '0;
    load_data  = '0;
    void'($urandom(32'h6459));
    read_patterns();
    patterns_ready = 1'b1;

    // image goes in while reset is low, then reset holds 4 more cycles
    preload_memory();
    repeat (4) @(posedge clk);
    #1;
    if (inst_valid !== 1'b0) begin
      flag_mismatch(T_RESET, "inst_valid", 32'(inst_valid), 32'h0);
    end
    if (halted !== 1'b0) begin
      flag_mismatch(T_RESET, "halted", 32'(halted), 32'h0);
    end
    rstn = 1'b1;

    if (step_npc_q.size() == 0) begin
      report_problem(T_RESET, "the pattern file holds no steps");
    end else begin
      run_step(0);
    end
    print_test_result(T_RESET);

    for (i = 1; i < step_npc_q.size(); i++) begin
      run_step(i);
    end
    print_test_result(T_REDIRECT);
    print_test_result(T_BACKPRES);

    // the last step must be the ebreak
    last_pc = (step_npc_q.size() > 1) ? step_npc_q[step_npc_q.size()-2] : RESET_PC;
    if (expected_inst(last_pc) !== EBREAK_INST) begin
      report_problem(T_HALT, "the last step does not fetch an ebreak");
    end
    if (halted !== 1'b1) begin
      flag_mismatch(T_HALT, "halted", 32'(halted), 32'h1);
    end
    repeat (HALT_CYCLES) begin
      @(posedge clk);
      #1;
      if (inst_valid !== 1'b0) begin
        flag_mismatch(T_HALT, "inst_valid", 32'(inst_valid), 32'h0);
      end
      if (halted !== 1'b1) begin
        flag_mismatch(T_HALT, "halted", 32'(halted), 32'h1);
      end
    end
    print_test_result(T_HALT);

    // back-pressure cycles fall between address accept and handoff
    if (fetch_count !== cnt_t'(accepted)) begin
      flag_mismatch(T_COUNTERS, "fetch_count", fetch_count, cnt_t'(accepted));
    end
    if (fetch_count !== cnt_t'(expect_fetches)) begin
      flag_mismatch(T_COUNTERS, "fetch_count", fetch_count, cnt_t'(expect_fetches));
    end
    if (wait_mem_cycles < cnt_t'(MEM_LATENCY * accepted + total_stalls)) begin
      flag_mismatch(T_COUNTERS, "wait_mem_cycles", wait_mem_cycles,
                    cnt_t'(MEM_LATENCY * accepted + total_stalls));
    end
    if (wait_exu_cycles < cnt_t'(accepted)) begin
      flag_mismatch(T_COUNTERS, "wait_exu_cycles", wait_exu_cycles, cnt_t'(accepted));
    end
    print_test_result(T_COUNTERS);

    failed_tests = 0;
    error_total  = 0;
    for (i = 0; i < N_TESTS; i++) begin
      if (test_errors[i] != 0) begin
        failed_tests++;
      end
      error_total += test_errors[i];
    end
    $display("%0d tests, %0d failed, %0d errors, %0d fetches, %0d stall cycles",
             N_TESTS, failed_tests, error_total, accepted, total_stalls);
    if (error_total == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: fetch_top.f
verilog/fetch_pkg.sv
verilog/ifu.sv
verilog/inst_mem.sv
verilog/fetch_perf.sv
verilog/fetch_top.sv
bench/fetch_tb.sv

// File: verilog/fetch_perf.sv
`timescale 1ns/1ps

module fetch_perf import fetch_pkg::*; (
  input  logic clk,
  input  logic rstn,

  // events from the fetch unit
  input  logic fetch_accept,
  input  logic inst_accept,

  // counters
  output cnt_t fetch_count,
  output cnt_t wait_mem_cycles,
  output cnt_t wait_exu_cycles
);

  perf_state_t perf_st;

  // state follows the fetch unit's handshakes
  always_ff @(posedge clk) begin
    if (!rstn) begin
      perf_st <= perf_none;
    end else begin
      case (perf_st)
        perf_wait_mem: begin
          if (inst_accept) begin
            perf_st <= perf_wait_exu;
          end
        end
        perf_wait_exu: begin
          if (fetch_accept) begin
            perf_st <= perf_wait_mem;
          end
        end
        default: begin
          if (fetch_accept) begin
            perf_st <= perf_wait_mem;
          end
        end
      endcase
    end
  end

  // one count per address handshake
  always_ff @(posedge clk) begin
    if (!rstn) begin
      fetch_count <= '0;
    end else if (fetch_accept) begin
      fetch_count <= fetch_count + 1'b1;
    end
  end

  // cycles between address accept and instruction handoff
  always_ff @(posedge clk) begin
    if (!rstn) begin
      wait_mem_cycles <= '0;
    end else if (perf_st == perf_wait_mem) begin
      wait_mem_cycles <= wait_mem_cycles + 1'b1;
    end
  end

  // cycles between handoff and the next address accept
  always_ff @(posedge clk) begin
    if (!rstn) begin
      wait_exu_cycles <= '0;
    end else if (perf_st == perf_wait_exu) begin
      wait_exu_cycles <= wait_exu_cycles + 1'b1;
    end
  end

endmodule

// File: verilog/fetch_pkg.sv
package fetch_pkg;

  // byte address as seen by the fetch unit and memory
  typedef logic [31:0] addr_t;

  // one instruction word
  typedef logic [31:0] inst_t;

  // memory read beat, two instructions wide
  typedef logic [63:0] beat_t;

  // performance counter value
  typedef logic [31:0] cnt_t;

  // axi arsize field
  typedef logic [2:0] axi_size_t;

  // 4-byte transfer
  localparam axi_size_t SIZE_WORD = 3'b010;

  // fetch stops once this instruction is handed to decode
  localparam inst_t EBREAK_INST = 32'h0010_0073;

  // where the fetch unit is spending its time
  typedef enum logic [1:0] {
    perf_none,
    perf_wait_mem,
    perf_wait_exu
  } perf_state_t;

endpackage

// File: verilog/fetch_top.sv
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; #(
  parameter addr_t RESET_PC    = 32'h8000_0000,
  parameter int    MEM_WORDS   = 64,
  parameter int    MEM_LATENCY = 2,
  localparam int   IDX_W       = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1
) (
  input  logic             clk,
  input  logic             rstn,

  // execute / decode side
  input  addr_t            npc,
  output addr_t            pc,
  output inst_t            inst,
  output logic             inst_valid,
  input  logic             inst_ready,
  output logic             halted,

  // memory preload
  input  logic             load_en,
  input  logic [IDX_W-1:0] load_addr,
  input  beat_t            load_data,

  // performance counters
  output cnt_t             fetch_count,
  output cnt_t             wait_mem_cycles,
  output cnt_t             wait_exu_cycles
);

  // read channel between fetch unit and memory
  addr_t     ar_addr;
  logic      ar_valid;
  logic      ar_ready;
  axi_size_t ar_size;
  beat_t     r_data;
  logic      r_valid;
  logic      r_ready;

  // perf events
  logic fetch_accept;
  logic inst_accept;

  ifu #(
    .RESET_PC(RESET_PC)
  ) ifu_inst (
    .clk         (clk),
    .rstn        (rstn),
    .npc         (npc),
    .pc          (pc),
    .inst        (inst),
    .inst_valid  (inst_valid),
    .inst_ready  (inst_ready),
    .halted      (halted),
    .ar_addr     (ar_addr),
    .ar_valid    (ar_valid),
    .ar_ready    (ar_ready),
    .ar_size     (ar_size),
    .r_data      (r_data),
    .r_valid     (r_valid),
    .r_ready     (r_ready),
    .fetch_accept(fetch_accept),
    .inst_accept (inst_accept)
  );

  inst_mem #(
    .MEM_WORDS  (MEM_WORDS),
    .MEM_LATENCY(MEM_LATENCY)
  ) inst_mem_inst (
    .clk      (clk),
    .rstn     (rstn),
    .ar_addr  (ar_addr),
    .ar_valid (ar_valid),
    .ar_ready (ar_ready),
    .ar_size  (ar_size),
    .r_data   (r_data),
    .r_valid  (r_valid),
    .r_ready  (r_ready),
    .load_en  (load_en),
    .load_addr(load_addr),
    .load_data(load_data)
  );

  fetch_perf fetch_perf_inst (
    .clk            (clk),
    .rstn           (rstn),
    .fetch_accept   (fetch_accept),
    .inst_accept    (inst_accept),
    .fetch_count    (fetch_count),
    .wait_mem_cycles(wait_mem_cycles),
    .wait_exu_cycles(wait_exu_cycles)
  );

endmodule

// File: verilog/ifu.sv
`timescale 1ns/1ps

module ifu import fetch_pkg::*; #(
  parameter addr_t RESET_PC = 32'h8000_0000
) (
  input  logic      clk,
  input  logic      rstn,

  // next pc from execute
  input  addr_t     npc,

  // instruction out to decode
  output addr_t     pc,
  output inst_t     inst,
  output logic      inst_valid,
  input  logic      inst_ready,
  output logic      halted,

  // read channel to instruction memory
  output addr_t     ar_addr,
  output logic      ar_valid,
  input  logic      ar_ready,
  output axi_size_t ar_size,
  input  beat_t     r_data,
  input  logic      r_valid,
  output logic      r_ready,

  // events for the perf block
  output logic      fetch_accept,
  output logic      inst_accept
);

  logic started;
  logic is_ebreak;

  // every fetch is a single word
  assign ar_size = SIZE_WORD;

  // decode handshake rides directly on the read data channel
  assign inst_valid = r_valid;
  assign r_ready    = inst_ready;

  // pc bit 2 picks the half of the 8-byte beat
  assign inst = pc[2] ? r_data[63:32] : r_data[31:0];

  assign fetch_accept = ar_valid && ar_ready;
  assign inst_accept  = inst_valid && inst_ready;

  assign is_ebreak = (inst == EBREAK_INST);

  // first read goes out one cycle after reset is released
  always_ff @(posedge clk) begin
    if (!rstn) begin
      started <= 1'b0;
    end else begin
      started <= 1'b1;
    end
  end

  // read request
  always_ff @(posedge clk) begin
    if (!rstn) begin
      ar_valid <= 1'b0;
      ar_addr  <= RESET_PC;
    end else begin
      if (!started) begin
        ar_valid <= 1'b1;
      end

      // memory took the address, drop the request
      if (fetch_accept) begin
        ar_valid <= 1'b0;
      end

      // decode took the instruction, move on to npc
      if (inst_accept) begin
        ar_addr <= npc;
        if (!is_ebreak) begin
          ar_valid <= 1'b1;
        end
      end
    end
  end

  // pc tracks the address of the read in flight
  always_ff @(posedge clk) begin
    if (!rstn) begin
      pc <= RESET_PC;
    end else if (fetch_accept) begin
      pc <= ar_addr;
    end
  end

  // sticky halt, only reset clears it
  always_ff @(posedge clk) begin
    if (!rstn) begin
      halted <= 1'b0;
    end else if (inst_accept && is_ebreak) begin
      halted <= 1'b1;
    end
  end

endmodule

// File: verilog/inst_mem.sv
`timescale 1ns/1ps

module inst_mem import fetch_pkg::*; #(
  parameter int  MEM_WORDS   = 64,
  parameter int  MEM_LATENCY = 2,
  localparam int IDX_W       = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1
) (
  input  logic             clk,
  input  logic             rstn,

  // read channel
  input  addr_t            ar_addr,
  input  logic             ar_valid,
  output logic             ar_ready,
  input  axi_size_t        ar_size,
  output beat_t            r_data,
  output logic             r_valid,
  input  logic             r_ready,

  // preload, one beat per cycle
  input  logic             load_en,
  input  logic [IDX_W-1:0] load_addr,
  input  beat_t            load_data
);

  // down-counter holds values 0 .. MEM_LATENCY-1
  localparam int LAT_W = (MEM_LATENCY > 1) ? $clog2(MEM_LATENCY) : 1;

  typedef enum logic [1:0] {
    mem_idle,
    mem_busy,
    mem_resp
  } mem_state_t;

  beat_t mem [MEM_WORDS];

  mem_state_t       state;
  logic [LAT_W-1:0] lat_cnt;
  addr_t            word_addr;
  logic [IDX_W-1:0] rd_idx;
  logic             addr_hs;
  logic             data_hs;
  beat_t            rd_beat;

  // ar_size is not decoded, a read always returns the whole beat

  assign ar_ready = (state == mem_idle);
  assign r_valid  = (state == mem_resp);
  assign r_data   = rd_beat;

  assign addr_hs = ar_valid && ar_ready;
  assign data_hs = r_valid && r_ready;

  // beat index wraps at the array size
  assign word_addr = ar_addr >> 3;
  assign rd_idx    = IDX_W'(word_addr % addr_t'(MEM_WORDS));

  // one read outstanding at a time
  always_ff @(posedge clk) begin
    if (!rstn) begin
      state   <= mem_idle;
      lat_cnt <= '0;
    end else begin
      case (state)
        mem_idle: begin
          if (addr_hs) begin
            state   <= mem_busy;
            lat_cnt <= LAT_W'(MEM_LATENCY - 1);
          end
        end
        mem_busy: begin
          if (lat_cnt == '0) begin
            state <= mem_resp;
          end else begin
            lat_cnt <= lat_cnt - 1'b1;
          end
        end
        mem_resp: begin
          // beat stays up until the fetch unit takes it
          if (data_hs) begin
            state <= mem_idle;
          end
        end
        default: begin
          state <= mem_idle;
        end
      endcase
    end
  end

  // capture the beat at address accept
  always_ff @(posedge clk) begin
    if (addr_hs) begin
      rd_beat <= mem[rd_idx];
    end
  end

  // preload write port
  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[load_addr] <= load_data;
    end
  end

endmodule
